// ==== include/cvxif_settings.svh ====
/*
 * Build settings for the coprocessor offload subsystem
 *   data width, transaction ID width, tval enable, accepted opcode
 */
`ifndef CVXIF_SETTINGS_SVH
`define CVXIF_SETTINGS_SVH

// Data width of the operands and the result
`define CVXIF_XLEN 32

// Width of the transaction ID carried from issue to writeback
`define CVXIF_TRANS_ID_BITS 3

// Exception tval carries the trapping instruction word when set
`define CVXIF_TVAL_EN 1

// Custom-0 major opcode
`define CVXIF_OPCODE 7'b0001011

`endif

// ==== logic/cvxif_pkg.sv ====
/*
 * Shared types of the coprocessor offload subsystem
 *   - illegal instruction cause code
 *   - coprocessor operation encoding
 *   - issue request and decode verdict
 *   - result, exception and writeback records
 */
`include "cvxif_settings.svh"

package cvxif_pkg;

  // Cause code raised for a rejected instruction
  localparam logic [`CVXIF_XLEN-1:0] ILLEGAL_INSTR = 2;

  // Operation of an accepted instruction
  typedef enum logic [2:0] {
    ADD,
    SUB,
    XOR,
    // Low half of the product
    MUL,
    // Unsigned minimum
    MINU,
    // Completes without writing a register
    NOWB
  } copro_op_e;

  // Request handed to the coprocessor at issue
  typedef struct packed {
    logic [31:0]                      instr;
    logic [`CVXIF_XLEN-1:0]           rs1;
    logic [`CVXIF_XLEN-1:0]           rs2;
    logic [`CVXIF_TRANS_ID_BITS-1:0]  id;
  } x_issue_req_t;

  // Decoder verdict, valid in the issue cycle
  typedef struct packed {
    logic       accept;
    copro_op_e  op;
    logic       we;
    logic [4:0] rd;
  } x_decode_t;

  // Result record returned by the execute pipeline
  typedef struct packed {
    logic [`CVXIF_TRANS_ID_BITS-1:0]  id;
    logic [`CVXIF_XLEN-1:0]           data;
    logic                             we;
    logic [4:0]                       rd;
  } x_result_t;

  // Exception record beside the writeback
  typedef struct packed {
    logic                   valid;
    logic [`CVXIF_XLEN-1:0] cause;
    logic [`CVXIF_XLEN-1:0] tval;
  } exception_t;

  // Writeback bundle, strobe and exception travel beside it
  typedef struct packed {
    logic [`CVXIF_TRANS_ID_BITS-1:0]  trans_id;
    logic [`CVXIF_XLEN-1:0]           result;
    logic                             we;
    logic [4:0]                       rd;
  } x_wb_t;

endpackage

// ==== logic/copro_decoder.sv ====
/*
 * Coprocessor decoder
 *   accepts or rejects an offloaded instruction
 *   selects operation, write enable and destination register
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module copro_decoder (
  input  logic [31:0]           instr_i,
  output cvxif_pkg::x_decode_t  decode_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // R-type fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Reject by default
    decode_o.accept = 1'b0;
    decode_o.op     = cvxif_pkg::NOWB;
    decode_o.we     = 1'b0;
    // Destination always taken from the rd field
    decode_o.rd     = instr_i[11:7];

    // Only custom-0 with funct7 zero is considered
    if (opcode == `CVXIF_OPCODE && funct7 == 7'd0) begin
      case (funct3)
        3'd0: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::ADD;
          decode_o.we     = 1'b1;
        end
        3'd1: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::SUB;
          decode_o.we     = 1'b1;
        end
        3'd2: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::XOR;
          decode_o.we     = 1'b1;
        end
        3'd3: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::MUL;
          decode_o.we     = 1'b1;
        end
        3'd4: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::MINU;
          decode_o.we     = 1'b1;
        end
        // Accepted, but nothing to write
        3'd7: begin
          decode_o.accept = 1'b1;
          decode_o.op     = cvxif_pkg::NOWB;
        end
        // funct3 5 and 6 are reserved
        default: decode_o.accept = 1'b0;
      endcase
    end
  end

endmodule

// ==== logic/copro_exec.sv ====
/*
 * Two-stage coprocessor execute pipeline
 *   stage one captures operands and starts the multiply
 *   stage two finishes the operation and registers the result record
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module copro_exec (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  input  cvxif_pkg::x_issue_req_t req_i,
  input  cvxif_pkg::x_decode_t    decode_i,
  output logic                    result_valid_o,
  output cvxif_pkg::x_result_t    result_o
);

  localparam int XLEN = `CVXIF_XLEN;
  localparam int HALF = XLEN / 2;

  // Stage one record with the partial products of the multiply
  typedef struct packed {
    logic [XLEN-1:0]                 rs1;
    logic [XLEN-1:0]                 rs2;
    cvxif_pkg::copro_op_e            op;
    logic [`CVXIF_TRANS_ID_BITS-1:0] id;
    logic                            we;
    logic [4:0]                      rd;
    logic [XLEN-1:0]                 mul_ll;
    logic [HALF-1:0]                 mul_cross;
  } s1_t;

  logic                 accepted;
  logic [XLEN-1:0]      rs1_lo_ext;
  logic [XLEN-1:0]      rs2_lo_ext;
  s1_t                  s1_d;
  s1_t                  s1_q;
  logic                 s1_valid_q;
  logic [XLEN-1:0]      mul_data;
  logic [XLEN-1:0]      exec_data;
  cvxif_pkg::x_result_t result_d;
  cvxif_pkg::x_result_t result_q;
  logic                 result_valid_q;

  // Only accepted requests enter the pipeline
  assign accepted = req_valid_i & decode_i.accept;

  // Low halves widened so the product keeps all its bits
  assign rs1_lo_ext = {{HALF{1'b0}}, req_i.rs1[HALF-1:0]};
  assign rs2_lo_ext = {{HALF{1'b0}}, req_i.rs2[HALF-1:0]};

  always_comb begin
    s1_d.rs1    = req_i.rs1;
    s1_d.rs2    = req_i.rs2;
    s1_d.op     = decode_i.op;
    s1_d.id     = req_i.id;
    s1_d.we     = decode_i.we;
    s1_d.rd     = decode_i.rd;
    // Low x low gives the full lower product
    s1_d.mul_ll = rs1_lo_ext * rs2_lo_ext;
    // Cross terms only matter modulo 2^HALF and high x high drops out
    s1_d.mul_cross = req_i.rs1[HALF-1:0] * req_i.rs2[XLEN-1:HALF]
                   + req_i.rs1[XLEN-1:HALF] * req_i.rs2[HALF-1:0];
  end

  // Stage one valid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= accepted;
    end
  end

  // Stage one payload
  always_ff @(posedge clk_i) begin
    if (accepted) begin
      s1_q <= s1_d;
    end
  end

  // Finish the multiply by shifting the cross terms into the top half
  assign mul_data = s1_q.mul_ll + {s1_q.mul_cross, {HALF{1'b0}}};

  always_comb begin
    case (s1_q.op)
      cvxif_pkg::ADD:  exec_data = s1_q.rs1 + s1_q.rs2;
      cvxif_pkg::SUB:  exec_data = s1_q.rs1 - s1_q.rs2;
      cvxif_pkg::XOR:  exec_data = s1_q.rs1 ^ s1_q.rs2;
      cvxif_pkg::MUL:  exec_data = mul_data;
      cvxif_pkg::MINU: exec_data = (s1_q.rs1 < s1_q.rs2) ? s1_q.rs1 : s1_q.rs2;
      // NOWB returns zero
      default:         exec_data = '0;
    endcase
    result_d.id   = s1_q.id;
    result_d.data = exec_data;
    result_d.we   = s1_q.we;
    result_d.rd   = s1_q.rd;
  end

  // Stage two valid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= s1_valid_q;
    end
  end

  // Stage two payload
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      result_q <= result_d;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

  // Accepted request returns its own result exactly two cycles later
  property p_exec_latency;
    @(posedge clk_i) disable iff (rst_i)
      accepted |-> ##2 (result_valid_o && result_o.id == $past(req_i.id, 2));
  endproperty
  a_exec_latency: assert property (p_exec_latency)
    else $error("copro_exec: result missing or wrong id two cycles after accept");

endmodule

// ==== logic/cvxif_issue_ctrl.sv ====
/*
 * Issue control for the coprocessor
 *   packs the issue signals into a coprocessor request
 *   two-stage delay line for rejected instructions
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module cvxif_issue_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            issue_valid_i,
  input  logic [31:0]                     issue_instr_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs1_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs2_i,
  input  logic [`CVXIF_TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic                            accept_i,
  output logic                            req_valid_o,
  output cvxif_pkg::x_issue_req_t         req_o,
  output logic                            x_illegal_o,
  output logic [`CVXIF_TRANS_ID_BITS-1:0] x_trans_id_o,
  output logic [31:0]                     x_off_instr_o
);

  // One entry of the reject line
  typedef struct packed {
    logic [`CVXIF_TRANS_ID_BITS-1:0] trans_id;
    logic [31:0]                     instr;
  } rej_entry_t;

  logic       push;
  rej_entry_t rej_d;
  logic [1:0] rej_valid_q;
  rej_entry_t rej0_q;
  rej_entry_t rej1_q;

  // Request goes out in the issue cycle
  assign req_valid_o = issue_valid_i;
  assign req_o.instr = issue_instr_i;
  assign req_o.rs1   = issue_rs1_i;
  assign req_o.rs2   = issue_rs2_i;
  assign req_o.id    = issue_trans_id_i;

  // Decoder said no, so the instruction takes the reject path
  assign push           = issue_valid_i & ~accept_i;
  assign rej_d.trans_id = issue_trans_id_i;
  assign rej_d.instr    = issue_instr_i;

  // Valid tags matched to the execute pipeline depth
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rej_valid_q <= 2'b00;
    end else begin
      rej_valid_q <= {rej_valid_q[0], push};
    end
  end

  // Payload moves only behind a valid tag
  always_ff @(posedge clk_i) begin
    if (push) begin
      rej0_q <= rej_d;
    end
    if (rej_valid_q[0]) begin
      rej1_q <= rej0_q;
    end
  end

  assign x_illegal_o   = rej_valid_q[1];
  assign x_trans_id_o  = rej1_q.trans_id;
  assign x_off_instr_o = rej1_q.instr;

  // Rejected issue comes back as illegal two cycles later with its own ID and word
  property p_reject_latency;
    @(posedge clk_i) disable iff (rst_i)
      push |-> ##2 (x_illegal_o &&
                    x_trans_id_o == $past(issue_trans_id_i, 2) &&
                    x_off_instr_o == $past(issue_instr_i, 2));
  endproperty
  a_reject_latency: assert property (p_reject_latency)
    else $error("cvxif_issue_ctrl: reject missing or wrong two cycles after issue");

endmodule

// ==== logic/cvxif_fu.sv ====
/*
 * Coprocessor functional unit
 *   merges results and illegal-instruction exceptions onto one writeback
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module cvxif_fu #(
  parameter type exception_t = cvxif_pkg::exception_t,
  parameter type x_result_t  = cvxif_pkg::x_result_t
) (
  input  logic                            x_illegal_i,
  input  logic [`CVXIF_TRANS_ID_BITS-1:0] x_trans_id_i,
  input  logic [31:0]                     x_off_instr_i,
  input  logic                            result_valid_i,
  input  x_result_t                       result_i,
  output logic                            wb_valid_o,
  output cvxif_pkg::x_wb_t                wb_o,
  output exception_t                      x_exception_o
);

  // Either source completes the instruction
  assign wb_valid_o = x_illegal_i | result_valid_i;

  always_comb begin
    // Illegal wins the trans ID, sources never overlap anyway
    wb_o.trans_id = x_illegal_i ? x_trans_id_i : result_i.id;
    wb_o.result   = result_i.data;
    // No register write unless a real result is present
    wb_o.we       = result_valid_i & result_i.we;
    wb_o.rd       = result_i.rd;
  end

  // Illegal-instruction exception
  always_comb begin
    x_exception_o       = '0;
    x_exception_o.valid = x_illegal_i;
    if (x_illegal_i) begin
      x_exception_o.cause = cvxif_pkg::ILLEGAL_INSTR;
      // Trapping instruction word as tval
      if (`CVXIF_TVAL_EN != 0) begin
        x_exception_o.tval[31:0] = x_off_instr_i;
      end
    end
  end

  // Both paths are two cycles deep, one completion per cycle at most
  always_comb begin
    a_one_source: assert final (!(x_illegal_i && result_valid_i))
      else $error("cvxif_fu: illegal and result complete in the same cycle");
  end

endmodule

// ==== logic/cvxif_subsys_top.sv ====
/*
 * Coprocessor offload subsystem top level
 *   issue control, decoder, execute pipeline, functional unit
 *   every instruction writes back two cycles after issue
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module cvxif_subsys_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            issue_valid_i,
  input  logic [31:0]                     issue_instr_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs1_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs2_i,
  input  logic [`CVXIF_TRANS_ID_BITS-1:0] issue_trans_id_i,
  output logic                            wb_valid_o,
  output cvxif_pkg::x_wb_t                wb_o,
  output cvxif_pkg::exception_t           wb_exception_o
);

  // Issue request to the coprocessor
  logic                            req_valid;
  cvxif_pkg::x_issue_req_t         req;

  // Decoder verdict, same cycle as the request
  cvxif_pkg::x_decode_t            decode;

  // Execute pipeline output
  logic                            result_valid;
  cvxif_pkg::x_result_t            result;

  // Reject line output
  logic                            x_illegal;
  logic [`CVXIF_TRANS_ID_BITS-1:0] x_trans_id;
  logic [31:0]                     x_off_instr;

  // Request packing and reject delay line
  cvxif_issue_ctrl issue_ctrl0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .issue_valid_i    (issue_valid_i),
    .issue_instr_i    (issue_instr_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .issue_trans_id_i (issue_trans_id_i),
    .accept_i         (decode.accept),
    .req_valid_o      (req_valid),
    .req_o            (req),
    .x_illegal_o      (x_illegal),
    .x_trans_id_o     (x_trans_id),
    .x_off_instr_o    (x_off_instr)
  );

  // Accept or reject
  copro_decoder decoder0 (
    .instr_i  (req.instr),
    .decode_o (decode)
  );

  // Two-stage execute
  copro_exec exec0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .decode_i       (decode),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  // Merge onto the writeback port
  cvxif_fu #(
    .exception_t (cvxif_pkg::exception_t),
    .x_result_t  (cvxif_pkg::x_result_t)
  ) fu0 (
    .x_illegal_i    (x_illegal),
    .x_trans_id_i   (x_trans_id),
    .x_off_instr_i  (x_off_instr),
    .result_valid_i (result_valid),
    .result_i       (result),
    .wb_valid_o     (wb_valid_o),
    .wb_o           (wb_o),
    .x_exception_o  (wb_exception_o)
  );

endmodule

// ==== verif/cvxif_checker.sv ====
/*
 * Writeback checker for the coprocessor offload subsystem
 *   reference model of the decode rule and the operations
 *   expected writeback queue, compare and latency check
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module cvxif_checker (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            issue_valid_i,
  input  logic [31:0]                     issue_instr_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs1_i,
  input  logic [`CVXIF_XLEN-1:0]          issue_rs2_i,
  input  logic [`CVXIF_TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic                            wb_valid_i,
  input  cvxif_pkg::x_wb_t                wb_i,
  input  cvxif_pkg::exception_t           wb_exception_i,
  output int                              err_count_o,
  output int                              checked_o,
  output int                              pending_o
);

  // Expected completion of one issued instruction
  typedef struct packed {
    logic                            accepted;
    logic [`CVXIF_TRANS_ID_BITS-1:0] trans_id;
    logic [`CVXIF_XLEN-1:0]          data;
    logic                            we;
    logic [4:0]                      rd;
    logic [`CVXIF_XLEN-1:0]          cause;
    logic [`CVXIF_XLEN-1:0]          tval;
  } expect_t;

  expect_t exp_q[$];
  int      due_q[$];
  int      cycle;
  int      errors;
  int      checked;
  expect_t exp_w;
  int      due_w;

  // Reference model straight from the decode table
  function automatic expect_t predict(input logic [31:0] instr,
                                      input logic [`CVXIF_XLEN-1:0] a,
                                      input logic [`CVXIF_XLEN-1:0] b,
                                      input logic [`CVXIF_TRANS_ID_BITS-1:0] id);
    expect_t e;
    e          = '0;
    e.trans_id = id;
    e.rd       = instr[11:7];
    if (instr[6:0] == `CVXIF_OPCODE && instr[31:25] == 7'd0 &&
        instr[14:12] != 3'd5 && instr[14:12] != 3'd6) begin
      e.accepted = 1'b1;
      e.we       = (instr[14:12] != 3'd7);
      case (instr[14:12])
        3'd0:    e.data = a + b;
        3'd1:    e.data = a - b;
        3'd2:    e.data = a ^ b;
        3'd3:    e.data = a * b;
        3'd4:    e.data = (a < b) ? a : b;
        default: e.data = '0;
      endcase
    end else begin
      // Illegal instruction raises cause code 2
      e.cause = `CVXIF_XLEN'd2;
      e.tval  = (`CVXIF_TVAL_EN != 0) ? instr : '0;
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [`CVXIF_XLEN-1:0] exp_v,
                               input logic [`CVXIF_XLEN-1:0] got_v);
    if (exp_v !== got_v) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, got_v);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle++;
      // Overdue entry means a lost writeback
      if (due_q.size() != 0 && due_q[0] < cycle) begin
        exp_w = exp_q.pop_front();
        due_w = due_q.pop_front();
        errors++;
        $display("Writeback for trans_id %0d never arrived (due cycle %0d)",
                 exp_w.trans_id, due_w);
      end
      if (!wb_valid_i && wb_exception_i.valid) begin
        errors++;
        $display("Exception valid at %0t without a writeback strobe", $time);
      end
      if (wb_valid_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected writeback at %0t with trans_id %0d", $time, wb_i.trans_id);
        end else begin
          exp_w = exp_q.pop_front();
          due_w = due_q.pop_front();
          checked++;
          compare_field("wb_valid_o cycle", due_w, cycle);
          compare_field("wb_o.trans_id", `CVXIF_XLEN'(exp_w.trans_id),
                        `CVXIF_XLEN'(wb_i.trans_id));
          compare_field("wb_o.we", `CVXIF_XLEN'(exp_w.we), `CVXIF_XLEN'(wb_i.we));
          compare_field("wb_exception_o.valid", `CVXIF_XLEN'(!exp_w.accepted),
                        `CVXIF_XLEN'(wb_exception_i.valid));
          if (exp_w.accepted) begin
            compare_field("wb_o.result", exp_w.data, wb_i.result);
            if (exp_w.we)
              compare_field("wb_o.rd", `CVXIF_XLEN'(exp_w.rd), `CVXIF_XLEN'(wb_i.rd));
          end else begin
            compare_field("wb_exception_o.cause", exp_w.cause, wb_exception_i.cause);
            compare_field("wb_exception_o.tval", exp_w.tval, wb_exception_i.tval);
          end
        end
      end
      // Every issue completes two cycles later
      if (issue_valid_i) begin
        exp_q.push_back(predict(issue_instr_i, issue_rs1_i, issue_rs2_i, issue_trans_id_i));
        due_q.push_back(cycle + 2);
      end
    end
  end

  assign err_count_o = errors;
  assign checked_o   = checked;
  assign pending_o   = exp_q.size();

endmodule

// ==== verif/cvxif_tb.sv ====
/*
 * Testbench top for the coprocessor offload subsystem
 *   clock, reset, xorshift random stimulus
 *   DUT and checker instances, per-test lines and final report
 */
`timescale 1ns/1ps
`include "cvxif_settings.svh"

module cvxif_tb;

  logic                            clk;
  logic                            rst;
  logic                            issue_valid;
  logic [31:0]                     issue_instr;
  logic [`CVXIF_XLEN-1:0]          issue_rs1;
  logic [`CVXIF_XLEN-1:0]          issue_rs2;
  logic [`CVXIF_TRANS_ID_BITS-1:0] issue_trans_id;
  logic                            wb_valid;
  cvxif_pkg::x_wb_t                wb;
  cvxif_pkg::exception_t           wb_exception;
  int                              errors;
  int                              checked;
  int                              pending;
  logic [31:0]                     rng_state;
  logic [`CVXIF_TRANS_ID_BITS-1:0] next_id;
  int                              tests;
  int                              timeouts;

  // 8 ns clock
  always #4 clk = ~clk;

  cvxif_subsys_top dut0 (
    .clk_i            (clk),
    .rst_i            (rst),
    .issue_valid_i    (issue_valid),
    .issue_instr_i    (issue_instr),
    .issue_rs1_i      (issue_rs1),
    .issue_rs2_i      (issue_rs2),
    .issue_trans_id_i (issue_trans_id),
    .wb_valid_o       (wb_valid),
    .wb_o             (wb),
    .wb_exception_o   (wb_exception)
  );

  cvxif_checker chk0 (
    .clk_i            (clk),
    .rst_i            (rst),
    .issue_valid_i    (issue_valid),
    .issue_instr_i    (issue_instr),
    .issue_rs1_i      (issue_rs1),
    .issue_rs2_i      (issue_rs2),
    .issue_trans_id_i (issue_trans_id),
    .wb_valid_i       (wb_valid),
    .wb_i             (wb),
    .wb_exception_i   (wb_exception),
    .err_count_o      (errors),
    .checked_o        (checked),
    .pending_o        (pending)
  );

  // 32-bit xorshift
  function automatic logic [31:0] rand32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // R-type word with random rs1, rs2 and rd fields
  function automatic logic [31:0] encode(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [6:0] opcode);
    logic [31:0] r;
    r = rand32();
    return {funct7, r[14:10], r[9:5], funct3, r[4:0], opcode};
  endfunction

  // Kind 0 breaks the opcode and kind 1 the funct7 while others keep custom-0
  function automatic logic [31:0] random_instr(input int kind, input logic [2:0] funct3);
    logic [31:0] r;
    logic [6:0]  op;
    logic [6:0]  f7;
    r  = rand32();
    op = r[6:0];
    f7 = r[13:7];
    if (op == `CVXIF_OPCODE)
      op = op ^ 7'h40;
    if (f7 == 7'd0)
      f7 = 7'd1;
    case (kind)
      0:       return encode(7'd0, funct3, op);
      1:       return encode(f7, funct3, `CVXIF_OPCODE);
      default: return encode(7'd0, funct3, `CVXIF_OPCODE);
    endcase
  endfunction

  task automatic issue_one(input logic [31:0] instr);
    logic [31:0] a;
    logic [31:0] b;
    a = rand32();
    b = rand32();
    // Equal operands now and then
    if (a[31:29] == 3'd0)
      b = a;
    @(posedge clk);
    issue_valid    <= 1'b1;
    issue_instr    <= instr;
    issue_rs1      <= a;
    issue_rs2      <= b;
    issue_trans_id <= next_id;
    next_id++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (pending != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("Timeout: %0d writebacks still pending after %0d cycles", pending, limit);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %0d %s: %0d errors, %0d writebacks checked so far",
             tests, name, errors - errs_before, checked);
  endtask

  initial begin
    int e0;
    int pick;
    clk            = 1'b0;
    rst            = 1'b1;
    issue_valid    = 1'b0;
    issue_instr    = '0;
    issue_rs1      = '0;
    issue_rs2      = '0;
    issue_trans_id = '0;
    rng_state      = 32'h5c55;
    next_id        = '0;
    tests          = 0;
    timeouts       = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // No issue after reset so any strobe is an error
    e0 = errors;
    repeat (12) @(negedge clk);
    report_test("idle after reset", e0);

    e0 = errors;
    for (int f3 = 0; f3 < 5; f3++) begin
      repeat (6) issue_one(random_instr(2, 3'(f3)));
      idle_cycle();
      wait_drain(20);
    end
    report_test("accepted operations", e0);

    e0 = errors;
    repeat (6) issue_one(random_instr(2, 3'd7));
    idle_cycle();
    wait_drain(20);
    report_test("no writeback operation", e0);

    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      issue_one(random_instr(0, 3'd0));
      issue_one(random_instr(1, 3'd2));
      issue_one(random_instr(2, 3'd5));
      issue_one(random_instr(2, 3'd6));
    end
    idle_cycle();
    wait_drain(20);
    report_test("rejected instructions", e0);

    // Mixed stream mostly back to back
    e0 = errors;
    for (int k = 0; k < 300; k++) begin
      pick = int'(rand32() & 32'h7);
      if (pick == 7)
        idle_cycle();
      issue_one(random_instr(pick, 3'(rand32() >> 29)));
    end
    idle_cycle();
    wait_drain(20);
    report_test("mixed back-to-back", e0);

    $display("%0d tests, %0d writebacks checked, %0d errors, %0d timeouts",
             tests, checked, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Global limit on simulated time
  initial begin
    #200000;
    $display("Simulation ran past its time limit");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
logic/cvxif_pkg.sv
logic/copro_decoder.sv
logic/copro_exec.sv
logic/cvxif_issue_ctrl.sv
logic/cvxif_fu.sv
logic/cvxif_subsys_top.sv
verif/cvxif_checker.sv
verif/cvxif_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the coprocessor offload testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

mkdir -p build &&
verilator --binary --timing --assert -f compile.f --top-module cvxif_tb \
  -Mdir build -o cvxif_sim > build/build.log 2>&1 ||
  { echo "Verilator build failed, see build/build.log"; exit 1; }

./build/cvxif_sim > build/sim.log 2>&1
cat build/sim.log
grep -q "^TEST PASSED$" build/sim.log && exit 0 || exit 1
